//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module soc_domain_tb \
  -f tb.f \
  -o soc_domain_sim

./obj_dir/soc_domain_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^sim passed$" sim.log; then
  exit 0
fi
exit 1

//--- src/apb_bridge.sv
// Turns one crossbar request at a time into an APB setup and access phase.
// A new request is taken only while idle_o is high. done_o pulses in the
// access cycle in which pready is seen, with prdata and pslverr.
`default_nettype none

module apb_bridge
  import soc_domain_pkg::*;
(
  input  logic     s_soc_clk,
  input  logic     s_soc_rstn,
  input  logic     valid_i,
  input  mem_req_t req_i,
  output logic     idle_o,
  output logic     done_o,
  output mem_rsp_t rsp_o,
  output apb_req_t apb_o,
  input  apb_rsp_t apb_i
);

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_SETUP  = 2'd1;
  localparam logic [1:0] ST_ACCESS = 2'd2;

  logic [1:0] state_q;
  mem_req_t   req_q;

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:   state_q <= valid_i ? ST_SETUP : ST_IDLE;
        ST_SETUP:  state_q <= ST_ACCESS;
        // stay in access while the slave stretches
        ST_ACCESS: state_q <= apb_i.pready ? ST_IDLE : ST_ACCESS;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge s_soc_clk) begin
    if (idle_o && valid_i) begin
      req_q <= req_i;
    end
  end

  assign idle_o = state_q == ST_IDLE;
  assign done_o = state_q == ST_ACCESS && apb_i.pready;

  always_comb begin
    apb_o.psel    = state_q != ST_IDLE;
    apb_o.penable = state_q == ST_ACCESS;
    apb_o.pwrite  = req_q.we;
    apb_o.index   = req_q.addr.regs.index;
    apb_o.pwdata  = req_q.wdata;
    rsp_o.rdata   = apb_i.prdata;
    rsp_o.err     = apb_i.pslverr;
  end

endmodule

`default_nettype wire

//--- src/boot_rom.hex
// boot ROM image, one 32-bit word per line in hex, word 0 first
00000297
02028293
30529073
1000a137
ff010113
00000513
00000593
30047073
0080006f
10500073
ffdff06f
c0ffee11
5a5a0f0f
0badf00d
13579bdf
2468ace0

//--- src/boot_rom.sv
// Read-only boot memory, loaded from src/boot_rom.hex relative to the
// directory the simulator runs in. One 32-bit word per line.
`default_nettype none

module boot_rom
  import soc_domain_pkg::*;
(
  input  logic                  s_soc_clk,
  input  logic                  en_i,
  input  logic [ROM_ROW_W-1:0]  row_i,
  output logic [DATA_WIDTH-1:0] rdata_o
);

  logic [DATA_WIDTH-1:0] rom_q [ROM_WORDS];

  initial begin
    $readmemh("src/boot_rom.hex", rom_q);
  end

  // word shows up the cycle after the enable
  always_ff @(posedge s_soc_clk) begin
    if (en_i) begin
      rdata_o <= rom_q[row_i];
    end
  end

endmodule

`default_nettype wire

//--- src/l2_ram_bank.sv
// One L2 bank with per-byte write enables and a registered read.
// A write also returns the word as it was before the write.
// Contents come up undefined after power-on.
`default_nettype none

module l2_ram_bank
  import soc_domain_pkg::*;
#(
  parameter  int unsigned L2_ROWS = 256,
  localparam int unsigned ROW_W   = $clog2(L2_ROWS)
) (
  input  logic                  s_soc_clk,
  input  logic                  en_i,
  input  logic                  we_i,
  input  logic [ROW_W-1:0]      row_i,
  input  logic [BE_WIDTH-1:0]   be_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,
  output logic [DATA_WIDTH-1:0] rdata_o
);

  logic [DATA_WIDTH-1:0] mem_q [L2_ROWS];

  always_ff @(posedge s_soc_clk) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < BE_WIDTH; b++) begin
          // byte lanes written independently
          if (be_i[b]) begin
            mem_q[row_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
      rdata_o <= mem_q[row_i];
    end
  end

endmodule

`default_nettype wire

//--- src/soc_ctrl_regs.sv
// SoC control registers on APB. pready is always high and byte enables
// do not reach this block. Reads return the value before a write.
// INFO is read-only; writes to it are dropped without an error.
`default_nettype none

module soc_ctrl_regs
  import soc_domain_pkg::*;
#(
  parameter int unsigned L2_ROWS = 256
) (
  input  logic                  s_soc_clk,
  input  logic                  s_soc_rstn,
  input  apb_req_t              apb_i,
  output apb_rsp_t              apb_o,
  output logic [ADDR_WIDTH-1:0] boot_addr_o,
  output logic                  fetch_en_o
);

  // bank count in 7:0, rows per bank in 23:8
  localparam logic [DATA_WIDTH-1:0] INFO_WORD = {8'h00, 16'(L2_ROWS), 8'(L2_BANKS)};

  logic [ADDR_WIDTH-1:0] boot_addr_q;
  logic                  fetch_en_q;
  logic [DATA_WIDTH-1:0] scratch_q;
  logic                  wr_en;

  assign wr_en = apb_i.psel && apb_i.penable && apb_i.pwrite;

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      boot_addr_q <= ROM_BASE;
      fetch_en_q  <= 1'b0;
      scratch_q   <= '0;
    end else if (wr_en) begin
      case (apb_i.index)
        REG_BOOT_ADDR: boot_addr_q <= apb_i.pwdata;
        REG_FETCH_EN:  fetch_en_q  <= apb_i.pwdata[0];
        REG_SCRATCH:   scratch_q   <= apb_i.pwdata;
        default:       ;
      endcase
    end
  end

  always_comb begin
    apb_o.pready  = 1'b1;
    apb_o.pslverr = 1'b0;
    case (apb_i.index)
      REG_BOOT_ADDR: apb_o.prdata = boot_addr_q;
      REG_FETCH_EN:  apb_o.prdata = {{(DATA_WIDTH-1){1'b0}}, fetch_en_q};
      REG_SCRATCH:   apb_o.prdata = scratch_q;
      REG_INFO:      apb_o.prdata = INFO_WORD;
      default: begin
        // unknown index
        apb_o.prdata  = '0;
        apb_o.pslverr = apb_i.psel;
      end
    endcase
  end

  assign boot_addr_o = boot_addr_q;
  assign fetch_en_o  = fetch_en_q;

endmodule

`default_nettype wire

//--- src/soc_domain.sv
// Memory system of the SoC domain as seen by its host and debug masters.
// Clock and reset come straight from the ports; no reset synchronizer.
// Request and response channels use a valid/ready handshake.
`default_nettype none

module soc_domain
  import soc_domain_pkg::*;
#(
  parameter int unsigned L2_ROWS = 256
) (
  input  logic                  s_soc_clk,
  input  logic                  s_soc_rstn,
  // host master
  input  logic                  host_req_valid_i,
  output logic                  host_req_ready_o,
  input  mem_req_t              host_req_i,
  output logic                  host_rsp_valid_o,
  input  logic                  host_rsp_ready_i,
  output mem_rsp_t              host_rsp_o,
  // debug master
  input  logic                  dbg_req_valid_i,
  output logic                  dbg_req_ready_o,
  input  mem_req_t              dbg_req_i,
  output logic                  dbg_rsp_valid_o,
  input  logic                  dbg_rsp_ready_i,
  output mem_rsp_t              dbg_rsp_o,
  // core control
  output logic [ADDR_WIDTH-1:0] boot_addr_o,
  output logic                  fetch_en_o
);

  localparam int unsigned ROW_W = $clog2(L2_ROWS);

  logic [L2_BANKS-1:0]                 s_l2_en;
  logic [L2_BANKS-1:0]                 s_l2_we;
  logic [L2_BANKS-1:0][ROW_W-1:0]      s_l2_row;
  logic [L2_BANKS-1:0][BE_WIDTH-1:0]   s_l2_be;
  logic [L2_BANKS-1:0][DATA_WIDTH-1:0] s_l2_wdata;
  logic [L2_BANKS-1:0][DATA_WIDTH-1:0] s_l2_rdata;

  logic                  s_rom_en;
  logic [ROM_ROW_W-1:0]  s_rom_row;
  logic [DATA_WIDTH-1:0] s_rom_rdata;

  logic     s_apb_valid;
  mem_req_t s_apb_req;
  logic     s_apb_idle;
  logic     s_apb_done;
  mem_rsp_t s_apb_rsp;
  apb_req_t s_apb_bus_req;
  apb_rsp_t s_apb_bus_rsp;

  // ****************************************
  // interconnect
  // ****************************************

  soc_xbar #(
    .L2_ROWS(L2_ROWS)
  ) soc_xbar_i (
    .s_soc_clk       (s_soc_clk),
    .s_soc_rstn      (s_soc_rstn),
    .host_req_valid_i(host_req_valid_i),
    .host_req_ready_o(host_req_ready_o),
    .host_req_i      (host_req_i),
    .host_rsp_valid_o(host_rsp_valid_o),
    .host_rsp_ready_i(host_rsp_ready_i),
    .host_rsp_o      (host_rsp_o),
    .dbg_req_valid_i (dbg_req_valid_i),
    .dbg_req_ready_o (dbg_req_ready_o),
    .dbg_req_i       (dbg_req_i),
    .dbg_rsp_valid_o (dbg_rsp_valid_o),
    .dbg_rsp_ready_i (dbg_rsp_ready_i),
    .dbg_rsp_o       (dbg_rsp_o),
    .l2_en_o         (s_l2_en),
    .l2_we_o         (s_l2_we),
    .l2_row_o        (s_l2_row),
    .l2_be_o         (s_l2_be),
    .l2_wdata_o      (s_l2_wdata),
    .l2_rdata_i      (s_l2_rdata),
    .rom_en_o        (s_rom_en),
    .rom_row_o       (s_rom_row),
    .rom_rdata_i     (s_rom_rdata),
    .apb_valid_o     (s_apb_valid),
    .apb_req_o       (s_apb_req),
    .apb_idle_i      (s_apb_idle),
    .apb_done_i      (s_apb_done),
    .apb_rsp_i       (s_apb_rsp)
  );

  // ****************************************
  // memories
  // ****************************************

  for (genvar b = 0; b < L2_BANKS; b++) begin : gen_l2_bank
    l2_ram_bank #(
      .L2_ROWS(L2_ROWS)
    ) l2_ram_bank_i (
      .s_soc_clk(s_soc_clk),
      .en_i     (s_l2_en[b]),
      .we_i     (s_l2_we[b]),
      .row_i    (s_l2_row[b]),
      .be_i     (s_l2_be[b]),
      .wdata_i  (s_l2_wdata[b]),
      .rdata_o  (s_l2_rdata[b])
    );
  end

  boot_rom boot_rom_i (
    .s_soc_clk(s_soc_clk),
    .en_i     (s_rom_en),
    .row_i    (s_rom_row),
    .rdata_o  (s_rom_rdata)
  );

  // ****************************************
  // peripherals
  // ****************************************

  apb_bridge apb_bridge_i (
    .s_soc_clk (s_soc_clk),
    .s_soc_rstn(s_soc_rstn),
    .valid_i   (s_apb_valid),
    .req_i     (s_apb_req),
    .idle_o    (s_apb_idle),
    .done_o    (s_apb_done),
    .rsp_o     (s_apb_rsp),
    .apb_o     (s_apb_bus_req),
    .apb_i     (s_apb_bus_rsp)
  );

  soc_ctrl_regs #(
    .L2_ROWS(L2_ROWS)
  ) soc_ctrl_regs_i (
    .s_soc_clk  (s_soc_clk),
    .s_soc_rstn (s_soc_rstn),
    .apb_i      (s_apb_bus_req),
    .apb_o      (s_apb_bus_rsp),
    .boot_addr_o(boot_addr_o),
    .fetch_en_o (fetch_en_o)
  );

endmodule

`default_nettype wire

//--- src/soc_domain_pkg.sv
// Shared constants, address map and bus types of the SoC memory system.
// Address bits 31:28 select the region. L2 is word-interleaved over the
// banks by word address bit 2. L2 and ROM rows alias above their size.
`default_nettype none

package soc_domain_pkg;

  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

  // region codes in address bits 31:28
  localparam logic [3:0] REGION_L2  = 4'h1;
  localparam logic [3:0] REGION_ROM = 4'h2;
  localparam logic [3:0] REGION_APB = 4'h3;

  localparam int unsigned L2_BANK_BITS = 1;
  localparam int unsigned L2_BANKS     = 1 << L2_BANK_BITS;
  localparam int unsigned L2_ROW_BITS  = 16;

  localparam int unsigned ROM_WORDS = 16;
  localparam int unsigned ROM_ROW_W = $clog2(ROM_WORDS);
  localparam logic [ADDR_WIDTH-1:0] ROM_BASE = {REGION_ROM, {(ADDR_WIDTH-4){1'b0}}};

  // control register indices
  localparam logic [3:0] REG_BOOT_ADDR = 4'd0;
  localparam logic [3:0] REG_FETCH_EN  = 4'd1;
  localparam logic [3:0] REG_SCRATCH   = 4'd2;
  localparam logic [3:0] REG_INFO      = 4'd3;

  // one address word, seen as an L2 location or as a register index
  typedef union packed {
    struct packed {
      logic [3:0]                                           region;
      logic [ADDR_WIDTH-L2_ROW_BITS-L2_BANK_BITS-7:0]       unused;
      logic [L2_ROW_BITS-1:0]                               row;
      logic [L2_BANK_BITS-1:0]                              bank;
      logic [1:0]                                           offset;
    } l2;
    struct packed {
      logic [3:0]            region;
      logic [ADDR_WIDTH-11:0] unused;
      logic [3:0]            index;
      logic [1:0]            offset;
    } regs;
  } soc_addr_u;

  typedef struct packed {
    soc_addr_u             addr;
    logic                  we;
    logic [BE_WIDTH-1:0]   be;
    logic [DATA_WIDTH-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err;
  } mem_rsp_t;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [3:0]            index;
    logic [DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

//--- src/soc_xbar.sv
// Two-master crossbar onto the L2 banks, the boot ROM and the APB bridge.
// One transaction outstanding per master. L2, ROM and error responses
// are valid one cycle after acceptance, APB ones when the bridge is done.
// Same-target clashes go to a per-target round-robin pointer.
`default_nettype none

module soc_xbar
  import soc_domain_pkg::*;
#(
  parameter  int unsigned L2_ROWS = 256,
  localparam int unsigned ROW_W   = $clog2(L2_ROWS)
) (
  input  logic                                s_soc_clk,
  input  logic                                s_soc_rstn,
  // host master
  input  logic                                host_req_valid_i,
  output logic                                host_req_ready_o,
  input  mem_req_t                            host_req_i,
  output logic                                host_rsp_valid_o,
  input  logic                                host_rsp_ready_i,
  output mem_rsp_t                            host_rsp_o,
  // debug master
  input  logic                                dbg_req_valid_i,
  output logic                                dbg_req_ready_o,
  input  mem_req_t                            dbg_req_i,
  output logic                                dbg_rsp_valid_o,
  input  logic                                dbg_rsp_ready_i,
  output mem_rsp_t                            dbg_rsp_o,
  // L2 banks
  output logic [L2_BANKS-1:0]                 l2_en_o,
  output logic [L2_BANKS-1:0]                 l2_we_o,
  output logic [L2_BANKS-1:0][ROW_W-1:0]      l2_row_o,
  output logic [L2_BANKS-1:0][BE_WIDTH-1:0]   l2_be_o,
  output logic [L2_BANKS-1:0][DATA_WIDTH-1:0] l2_wdata_o,
  input  logic [L2_BANKS-1:0][DATA_WIDTH-1:0] l2_rdata_i,
  // boot ROM
  output logic                                rom_en_o,
  output logic [ROM_ROW_W-1:0]                rom_row_o,
  input  logic [DATA_WIDTH-1:0]               rom_rdata_i,
  // APB bridge
  output logic                                apb_valid_o,
  output mem_req_t                            apb_req_o,
  input  logic                                apb_idle_i,
  input  logic                                apb_done_i,
  input  mem_rsp_t                            apb_rsp_i
);

  // target codes, banks use their own index
  localparam logic [2:0] T_ROM = 3'(L2_BANKS);
  localparam logic [2:0] T_APB = 3'(L2_BANKS + 1);
  localparam logic [2:0] T_ERR = 3'(L2_BANKS + 2);

  mem_req_t [1:0]      req;
  logic     [1:0]      valid;
  logic     [1:0]      ready;
  logic     [1:0]      accept;
  logic     [1:0]      want;
  logic     [1:0]      lose;
  logic                clash;
  logic     [1:0][2:0] tgt;
  logic     [1:0]      rsp_ready;
  logic     [1:0]      rsp_valid;
  mem_rsp_t [1:0]      live;
  mem_rsp_t [1:0]      rsp;

  logic     [1:0]          busy_q;
  logic     [1:0]          rd_pend_q;
  logic     [1:0]          held_q;
  logic     [1:0][2:0]     src_q;
  mem_rsp_t [1:0]          rsp_q;
  logic     [L2_BANKS+1:0] rr_q;
  logic                    apb_owner_q;

  // master 0 is host, master 1 is debug
  assign req              = {dbg_req_i, host_req_i};
  assign valid            = {dbg_req_valid_i, host_req_valid_i};
  assign rsp_ready        = {dbg_rsp_ready_i, host_rsp_ready_i};
  assign host_req_ready_o = ready[0];
  assign dbg_req_ready_o  = ready[1];
  assign host_rsp_valid_o = rsp_valid[0];
  assign dbg_rsp_valid_o  = rsp_valid[1];
  assign host_rsp_o       = rsp[0];
  assign dbg_rsp_o        = rsp[1];

  // ****************************************
  // decode and arbitration
  // ****************************************

  always_comb begin
    for (int m = 0; m < 2; m++) begin
      case (req[m].addr.l2.region)
        REGION_L2:  tgt[m] = 3'(req[m].addr.l2.bank);
        REGION_ROM: tgt[m] = req[m].we ? T_ERR : T_ROM;
        REGION_APB: tgt[m] = T_APB;
        default:    tgt[m] = T_ERR;
      endcase
      want[m] = valid[m] && !busy_q[m];
    end
    // error responses need no shared target
    clash = want[0] && want[1] && tgt[0] == tgt[1] && tgt[0] != T_ERR;
    for (int m = 0; m < 2; m++) begin
      lose[m]   = clash && rr_q[tgt[m][1:0]] != m[0];
      ready[m]  = !busy_q[m] &&
                  !(want[m] && (lose[m] || (tgt[m] == T_APB && !apb_idle_i)));
      accept[m] = valid[m] && ready[m];
    end
  end

  // target ports, driven by whichever master was accepted
  always_comb begin
    logic                                l2_sel;
    logic                                rom_sel;
    logic                                apb_sel;
    logic [L2_ROW_BITS+L2_BANK_BITS-1:0] rom_word;
    for (int b = 0; b < L2_BANKS; b++) begin
      l2_sel        = accept[1] && tgt[1] == 3'(b);
      l2_en_o[b]    = (accept[0] && tgt[0] == 3'(b)) || l2_sel;
      l2_we_o[b]    = req[l2_sel].we;
      l2_row_o[b]   = req[l2_sel].addr.l2.row[ROW_W-1:0];
      l2_be_o[b]    = req[l2_sel].be;
      l2_wdata_o[b] = req[l2_sel].wdata;
    end
    rom_sel     = accept[1] && tgt[1] == T_ROM;
    rom_en_o    = (accept[0] && tgt[0] == T_ROM) || rom_sel;
    rom_word    = {req[rom_sel].addr.l2.row, req[rom_sel].addr.l2.bank};
    rom_row_o   = rom_word[ROM_ROW_W-1:0];
    apb_sel     = accept[1] && tgt[1] == T_APB;
    apb_valid_o = (accept[0] && tgt[0] == T_APB) || apb_sel;
    apb_req_o   = req[apb_sel];
  end

  // ****************************************
  // response path
  // ****************************************

  always_comb begin
    for (int m = 0; m < 2; m++) begin
      live[m].err   = 1'b0;
      live[m].rdata = (src_q[m] == T_ROM) ? rom_rdata_i
                                          : l2_rdata_i[src_q[m][L2_BANK_BITS-1:0]];
      // memory data passes straight through in its first cycle
      rsp[m]       = rd_pend_q[m] ? live[m] : rsp_q[m];
      rsp_valid[m] = rd_pend_q[m] || held_q[m];
    end
  end

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      busy_q      <= '0;
      rd_pend_q   <= '0;
      held_q      <= '0;
      rr_q        <= '0;
      apb_owner_q <= 1'b0;
    end else begin
      for (int m = 0; m < 2; m++) begin
        rd_pend_q[m] <= accept[m] && tgt[m] <= T_ROM;
        if (accept[m]) begin
          busy_q[m] <= 1'b1;
          if (clash) begin
            rr_q[tgt[m][1:0]] <= ~rr_q[tgt[m][1:0]];
          end
          if (tgt[m] == T_APB) begin
            apb_owner_q <= m[0];
          end
        end else if (rsp_valid[m] && rsp_ready[m]) begin
          busy_q[m] <= 1'b0;
        end
        if (rsp_valid[m] && rsp_ready[m]) begin
          held_q[m] <= 1'b0;
        end else if (rd_pend_q[m] || (accept[m] && tgt[m] == T_ERR) ||
                     (apb_done_i && apb_owner_q == m[0])) begin
          held_q[m] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge s_soc_clk) begin
    for (int m = 0; m < 2; m++) begin
      if (accept[m]) begin
        src_q[m] <= tgt[m];
      end
      if (rd_pend_q[m]) begin
        rsp_q[m] <= live[m];
      end else if (accept[m] && tgt[m] == T_ERR) begin
        rsp_q[m] <= '{rdata: '0, err: 1'b1};
      end else if (apb_done_i && apb_owner_q == m[0]) begin
        rsp_q[m] <= apb_rsp_i;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb.f
src/soc_domain_pkg.sv
src/l2_ram_bank.sv
src/boot_rom.sv
src/apb_bridge.sv
src/soc_ctrl_regs.sv
src/soc_xbar.sv
src/soc_domain.sv
verif/soc_domain_tb.sv

//--- verif/soc_domain_tb.sv
// Self-checking testbench for the SoC memory system.
// Run from the project root so that src/boot_rom.hex is found.
// L2 traffic stays in the first 32 words, all of them written before any read.
`default_nettype none

module soc_domain_tb
  import soc_domain_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned L2_ROWS      = 256;
  localparam int unsigned L2_WORDS     = 32;
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned N_FILL       = 32;
  localparam int unsigned N_L2_RAND    = 48;
  localparam int unsigned N_ROM        = 18;
  localparam int unsigned N_REG        = 10;
  localparam int unsigned N_UNMAPPED   = 3;
  localparam int unsigned N_MIX        = 120;
  localparam int unsigned N_TRANS      = N_FILL + N_L2_RAND + N_ROM + N_REG + N_UNMAPPED + N_MIX;
  localparam int unsigned CYCLE_LIMIT  = N_TRANS * 20 + RESET_CYCLES;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
  localparam logic [31:0] L2_BASE      = 32'h1000_0000;
  localparam logic [31:0] APB_BASE     = 32'h3000_0000;
  localparam logic [31:0] INFO_WORD    = {8'h00, 16'(L2_ROWS), 8'd2};

  typedef struct packed {
    mem_rsp_t rsp;
    logic     we;
    logic     apb;
  } expect_t;

  logic        s_soc_clk;
  logic        s_soc_rstn;
  logic [1:0]  req_valid;
  logic [1:0]  req_ready;
  mem_req_t    req_d [2];
  logic [1:0]  rsp_valid;
  logic [1:0]  rsp_ready;
  mem_rsp_t    rsp [2];
  logic [31:0] boot_addr_o;
  logic        fetch_en_o;

  // stimulus and model state
  mem_req_t    cmd_q [2][$];
  expect_t     exp_q [2][$];
  logic [1:0]  acc_seen;
  logic [1:0]  valid_seen;
  int unsigned acc_cycle [2];
  logic [31:0] lfsr_q = 32'h309b;
  int unsigned cycles;
  logic [31:0] rom_words [ROM_WORDS];
  logic [31:0] l2_shadow [2*L2_ROWS];
  logic [31:0] boot_shadow;
  logic        fetch_shadow;
  logic [31:0] scratch_shadow;

  soc_domain #(
    .L2_ROWS(L2_ROWS)
  ) soc_domain_i (
    .s_soc_clk       (s_soc_clk),
    .s_soc_rstn      (s_soc_rstn),
    .host_req_valid_i(req_valid[0]),
    .host_req_ready_o(req_ready[0]),
    .host_req_i      (req_d[0]),
    .host_rsp_valid_o(rsp_valid[0]),
    .host_rsp_ready_i(rsp_ready[0]),
    .host_rsp_o      (rsp[0]),
    .dbg_req_valid_i (req_valid[1]),
    .dbg_req_ready_o (req_ready[1]),
    .dbg_req_i       (req_d[1]),
    .dbg_rsp_valid_o (rsp_valid[1]),
    .dbg_rsp_ready_i (rsp_ready[1]),
    .dbg_rsp_o       (rsp[1]),
    .boot_addr_o     (boot_addr_o),
    .fetch_en_o      (fetch_en_o)
  );

  initial begin
    s_soc_clk = 1'b0;
    forever begin
      #50 s_soc_clk = ~s_soc_clk;
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge s_soc_clk);
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("sim failed");
        $fatal(1, "timeout");
      end
    end
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  // ****************************************
  // reference model
  // ****************************************

  function automatic mem_rsp_t expect_rsp(input mem_req_t r);
    mem_rsp_t    e;
    logic [31:0] a;
    a = r.addr;
    e.rdata = '0;
    e.err   = 1'b0;
    case (a[31:28])
      REGION_L2: e.rdata = l2_shadow[{a[10:3], a[2]}];
      REGION_ROM: begin
        if (r.we) begin
          e.err = 1'b1;
        end else begin
          e.rdata = rom_words[a[5:2]];
        end
      end
      REGION_APB: begin
        case (a[5:2])
          4'd0:    e.rdata = boot_shadow;
          4'd1:    e.rdata = {31'b0, fetch_shadow};
          4'd2:    e.rdata = scratch_shadow;
          4'd3:    e.rdata = INFO_WORD;
          default: e.err = 1'b1;
        endcase
      end
      default: e.err = 1'b1;
    endcase
    return e;
  endfunction

  task automatic apply_req(input mem_req_t r);
    logic [31:0] a;
    a = r.addr;
    if (r.we && a[31:28] == REGION_L2) begin
      for (int b = 0; b < 4; b++) begin
        if (r.be[b]) begin
          l2_shadow[{a[10:3], a[2]}][8*b +: 8] = r.wdata[8*b +: 8];
        end
      end
    end else if (r.we && a[31:28] == REGION_APB) begin
      case (a[5:2])
        4'd0:    boot_shadow = r.wdata;
        4'd1:    fetch_shadow = r.wdata[0];
        4'd2:    scratch_shadow = r.wdata;
        default: ;
      endcase
    end
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // ****************************************
  // stimulus
  // ****************************************

  task automatic push_req(input int m, input logic [31:0] addr, input logic we,
                          input logic [3:0] be, input logic [31:0] wdata);
    mem_req_t r;
    r.addr  = addr;
    r.we    = we;
    r.be    = be;
    r.wdata = wdata;
    cmd_q[m].push_back(r);
  endtask

  task automatic push_random(input int m);
    logic [31:0] addr;
    logic [3:0]  idx;
    case (rand_bits(2))
      0, 1:    addr = L2_BASE | (rand_bits(5) << 2);
      2:       addr = ROM_BASE | (rand_bits(4) << 2);
      default: begin
        idx  = 4'(rand_bits(3));
        // unknown index 4 now and then, mostly scratch
        addr = APB_BASE | ((idx > 4) ? 32'h8 : 32'(idx) << 2);
      end
    endcase
    push_req(m, addr, rand_bits(1), rand_bits(4), rand_bits(32));
  endtask

  // drives on falling edges until every queued request has its response
  task automatic run_traffic(input bit random_ready);
    bit done;
    done = 1'b0;
    while (!done) begin
      @(negedge s_soc_clk);
      for (int m = 0; m < 2; m++) begin
        if (acc_seen[m]) begin
          req_valid[m] = 1'b0;
          acc_seen[m]  = 1'b0;
        end
        if (!req_valid[m] && cmd_q[m].size() > 0) begin
          req_d[m]     = cmd_q[m].pop_front();
          req_valid[m] = 1'b1;
        end
        rsp_ready[m] = random_ready ? (rand_bits(2) != 0) : 1'b1;
      end
      done = req_valid == 2'b00 && cmd_q[0].size() == 0 && cmd_q[1].size() == 0 &&
             exp_q[0].size() == 0 && exp_q[1].size() == 0;
    end
  endtask

  // ****************************************
  // response checker
  // ****************************************

  // samples just before each rising edge, where all signals are settled
  initial begin
    expect_t     e;
    int unsigned lat;
    forever begin
      @(negedge s_soc_clk);
      #49;
      if (s_soc_rstn !== 1'b1) begin
        continue;
      end
      for (int m = 0; m < 2; m++) begin
        // first cycle of a response, latency counted from acceptance
        if (rsp_valid[m] && !valid_seen[m]) begin
          if (exp_q[m].size() == 0) begin
            $display("master %0d returned a response with no request outstanding", m);
            $display("sim failed");
            $fatal(1, "extra response");
          end
          e   = exp_q[m][0];
          lat = cycles - acc_cycle[m];
          if (e.apb) begin
            check_eq(32'(lat >= 3), 32'h1, $sformatf("master %0d APB latency >= 3", m));
          end else begin
            check_eq(lat, 32'd1, $sformatf("master %0d response latency", m));
          end
          valid_seen[m] = 1'b1;
        end else if (!rsp_valid[m] && valid_seen[m]) begin
          $display("master %0d dropped rsp_valid before the response was taken", m);
          $display("sim failed");
          $fatal(1, "dropped response");
        end
        if (rsp_valid[m] && rsp_ready[m]) begin
          e = exp_q[m].pop_front();
          check_eq(32'(rsp[m].err), 32'(e.rsp.err), $sformatf("master %0d err", m));
          if (!e.we || e.rsp.err) begin
            check_eq(rsp[m].rdata, e.rsp.rdata, $sformatf("master %0d rdata", m));
          end
          valid_seen[m] = 1'b0;
        end
        if (req_valid[m] && req_ready[m]) begin
          e.rsp = expect_rsp(req_d[m]);
          e.we  = req_d[m].we;
          e.apb = req_d[m].addr.l2.region == REGION_APB;
          apply_req(req_d[m]);
          exp_q[m].push_back(e);
          acc_cycle[m] = cycles;
          acc_seen[m]  = 1'b1;
        end
      end
    end
  end

  initial begin
    $readmemh("src/boot_rom.hex", rom_words);
    req_valid      = '0;
    req_d[0]       = '0;
    req_d[1]       = '0;
    rsp_ready      = 2'b11;
    acc_seen       = '0;
    valid_seen     = '0;
    s_soc_rstn     = 1'b0;
    boot_shadow    = ROM_BASE;
    fetch_shadow   = 1'b0;
    scratch_shadow = '0;
    repeat (RESET_CYCLES) @(posedge s_soc_clk);
    @(negedge s_soc_clk);
    s_soc_rstn = 1'b1;
    #49;
    check_eq(32'(rsp_valid), 32'h0, "rsp_valid after reset");
    check_eq(32'(req_ready), 32'h3, "req_ready after reset");
    check_eq(32'(fetch_en_o), 32'h0, "fetch_en_o after reset");
    check_eq(boot_addr_o, ROM_BASE, "boot_addr_o after reset");

    // L2 fill, pattern built from the whole address
    for (int w = 0; w < L2_WORDS; w++) begin
      push_req(w / 16, L2_BASE + 4 * w, 1'b1, 4'hf, (L2_BASE + 4 * w) * 32'h9e37_79b1);
    end
    run_traffic(1'b0);

    // random byte-enabled writes, then reads
    for (int m = 0; m < 2; m++) begin
      for (int i = 0; i < 12; i++) begin
        push_req(m, L2_BASE | (rand_bits(5) << 2), 1'b1, rand_bits(4), rand_bits(32));
      end
    end
    for (int m = 0; m < 2; m++) begin
      for (int i = 0; i < 12; i++) begin
        push_req(m, L2_BASE | (rand_bits(5) << 2), 1'b0, 4'hf, '0);
      end
    end
    run_traffic(1'b0);

    // boot ROM reads, one write that must fail
    for (int r = 0; r < ROM_WORDS; r++) begin
      push_req(0, ROM_BASE + 4 * r, 1'b0, 4'hf, '0);
    end
    push_req(1, ROM_BASE + 12, 1'b1, 4'hf, 32'hdead_beef);
    push_req(1, ROM_BASE + 12, 1'b0, 4'hf, '0);
    run_traffic(1'b0);

    // control registers
    push_req(0, APB_BASE + 0, 1'b1, 4'hf, 32'h1000_0040);
    push_req(0, APB_BASE + 0, 1'b0, 4'hf, '0);
    push_req(0, APB_BASE + 4, 1'b1, 4'hf, 32'h0000_0001);
    push_req(0, APB_BASE + 4, 1'b0, 4'hf, '0);
    push_req(0, APB_BASE + 8, 1'b1, 4'hf, 32'hcafe_1234);
    push_req(0, APB_BASE + 8, 1'b0, 4'hf, '0);
    push_req(0, APB_BASE + 12, 1'b1, 4'hf, 32'hffff_ffff);
    push_req(0, APB_BASE + 12, 1'b0, 4'hf, '0);
    push_req(0, APB_BASE + 16, 1'b0, 4'hf, '0);
    push_req(0, APB_BASE + 16, 1'b1, 4'hf, 32'h1);
    run_traffic(1'b0);
    check_eq(boot_addr_o, boot_shadow, "boot_addr_o after write");
    check_eq(32'(fetch_en_o), 32'(fetch_shadow), "fetch_en_o after write");

    // unmapped regions
    push_req(1, 32'h0000_1234, 1'b0, 4'hf, '0);
    push_req(1, 32'h4000_0010, 1'b1, 4'hf, 32'h5555_aaaa);
    push_req(0, 32'hf000_0000, 1'b0, 4'hf, '0);
    run_traffic(1'b0);

    // both masters at once with random back-pressure
    for (int i = 0; i < N_MIX / 2; i++) begin
      push_random(0);
      push_random(1);
    end
    run_traffic(1'b1);
    check_eq(boot_addr_o, boot_shadow, "boot_addr_o after mixed traffic");
    check_eq(32'(fetch_en_o), 32'(fetch_shadow), "fetch_en_o after mixed traffic");

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
